//--- Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module l15_adapter_top \
		l15_adapter_pkg.sv req_slot.sv l15_req_arbiter.sv l15_resp_demux.sv l15_adapter_top.sv

sim:
	verilator --binary --timing --assert --top-module tb_l15_adapter -f src.f -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- l15_adapter_pkg.sv
// L1.5 adapter shared definitions
// Widths of the request and return fields, the request command
// encoding and the state encoding of the arbiter output register.

`default_nettype none

package l15_adapter_pkg;

  // Physical address width in bits
  localparam int ADDR_W = 40;

  // Transaction id carried from requester to L1.5 and back
  localparam int ID_W = 4;

  // Access size as log2 of the byte count
  localparam int SIZE_W = 3;

  // Request and return command
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_cmd_e;

  // Arbiter output register occupancy
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_SEND = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

//--- l15_adapter_top.sv
// L1.5 adapter top level
// Funnels the requester ports into one L1.5 request channel through
// per-port request slots and a round-robin arbiter, and routes the
// L1.5 returns back to the issuing port.

`timescale 1ns/1ps
`default_nettype none

module l15_adapter_top #(
  parameter int  NPORTS = 5,
  parameter int  DATA_W = 64,
  localparam int PID_W  = (NPORTS > 1) ? $clog2(NPORTS) : 1
) (
  input  wire logic                                clk_i,
  input  wire logic                                arst_n_i,
  // Requester request side
  input  wire logic                                req_valid_i       [NPORTS],
  output logic                                     req_ready_o       [NPORTS],
  input  l15_adapter_pkg::mem_cmd_e                req_cmd_i         [NPORTS],
  input  wire logic [l15_adapter_pkg::ADDR_W-1:0]  req_addr_i        [NPORTS],
  input  wire logic [l15_adapter_pkg::SIZE_W-1:0]  req_size_i        [NPORTS],
  input  wire logic [l15_adapter_pkg::ID_W-1:0]    req_id_i          [NPORTS],
  input  wire logic                                req_cacheable_i   [NPORTS],
  input  wire logic                                req_wdata_valid_i [NPORTS],
  input  wire logic [DATA_W-1:0]                   req_wdata_i       [NPORTS],
  // Requester response side
  output logic                                     resp_valid_o      [NPORTS],
  input  wire logic                                resp_ready_i      [NPORTS],
  output l15_adapter_pkg::mem_cmd_e                resp_cmd_o        [NPORTS],
  output logic [l15_adapter_pkg::ID_W-1:0]         resp_id_o         [NPORTS],
  output logic [DATA_W-1:0]                        resp_rdata_o      [NPORTS],
  output logic                                     resp_error_o      [NPORTS],
  // L1.5 request channel
  output logic                                     l15_req_valid_o,
  input  wire logic                                l15_req_ready_i,
  output l15_adapter_pkg::mem_cmd_e                l15_req_cmd_o,
  output logic [l15_adapter_pkg::ADDR_W-1:0]       l15_req_addr_o,
  output logic [l15_adapter_pkg::SIZE_W-1:0]       l15_req_size_o,
  output logic [l15_adapter_pkg::ID_W-1:0]         l15_req_id_o,
  output logic                                     l15_req_cacheable_o,
  output logic [DATA_W-1:0]                        l15_req_wdata_o,
  output logic [PID_W-1:0]                         l15_req_pid_o,
  // L1.5 return channel
  input  wire logic                                l15_rtrn_valid_i,
  output logic                                     l15_rtrn_ready_o,
  input  wire logic [PID_W-1:0]                    l15_rtrn_pid_i,
  input  l15_adapter_pkg::mem_cmd_e                l15_rtrn_cmd_i,
  input  wire logic [l15_adapter_pkg::ID_W-1:0]    l15_rtrn_id_i,
  input  wire logic [DATA_W-1:0]                   l15_rtrn_rdata_i,
  input  wire logic                                l15_rtrn_error_i
);

  // Slot to arbiter
  logic                             slot_valid     [NPORTS];
  logic                             slot_grant     [NPORTS];
  l15_adapter_pkg::mem_cmd_e        slot_cmd       [NPORTS];
  logic [l15_adapter_pkg::ADDR_W-1:0] slot_addr    [NPORTS];
  logic [l15_adapter_pkg::SIZE_W-1:0] slot_size    [NPORTS];
  logic [l15_adapter_pkg::ID_W-1:0] slot_id        [NPORTS];
  logic                             slot_cacheable [NPORTS];
  logic [DATA_W-1:0]                slot_wdata     [NPORTS];

  // One slot per requester port
  for (genvar p = 0; p < NPORTS; p++) begin : g_slot
    req_slot #(
      .DATA_W (DATA_W)
    ) u_slot (
      .clk_i             (clk_i),
      .arst_n_i          (arst_n_i),
      .req_valid_i       (req_valid_i[p]),
      .req_cmd_i         (req_cmd_i[p]),
      .req_addr_i        (req_addr_i[p]),
      .req_size_i        (req_size_i[p]),
      .req_id_i          (req_id_i[p]),
      .req_cacheable_i   (req_cacheable_i[p]),
      .req_wdata_valid_i (req_wdata_valid_i[p]),
      .req_wdata_i       (req_wdata_i[p]),
      .req_ready_o       (req_ready_o[p]),
      .grant_i           (slot_grant[p]),
      .slot_valid_o      (slot_valid[p]),
      .slot_cmd_o        (slot_cmd[p]),
      .slot_addr_o       (slot_addr[p]),
      .slot_size_o       (slot_size[p]),
      .slot_id_o         (slot_id[p]),
      .slot_cacheable_o  (slot_cacheable[p]),
      .slot_wdata_o      (slot_wdata[p])
    );
  end

  l15_req_arbiter #(
    .NPORTS (NPORTS),
    .DATA_W (DATA_W)
  ) u_arb (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .slot_valid_i        (slot_valid),
    .slot_cmd_i          (slot_cmd),
    .slot_addr_i         (slot_addr),
    .slot_size_i         (slot_size),
    .slot_id_i           (slot_id),
    .slot_cacheable_i    (slot_cacheable),
    .slot_wdata_i        (slot_wdata),
    .grant_o             (slot_grant),
    .l15_req_valid_o     (l15_req_valid_o),
    .l15_req_ready_i     (l15_req_ready_i),
    .l15_req_cmd_o       (l15_req_cmd_o),
    .l15_req_addr_o      (l15_req_addr_o),
    .l15_req_size_o      (l15_req_size_o),
    .l15_req_id_o        (l15_req_id_o),
    .l15_req_cacheable_o (l15_req_cacheable_o),
    .l15_req_wdata_o     (l15_req_wdata_o),
    .l15_req_pid_o       (l15_req_pid_o)
  );

  l15_resp_demux #(
    .NPORTS (NPORTS),
    .DATA_W (DATA_W)
  ) u_demux (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .l15_rtrn_valid_i (l15_rtrn_valid_i),
    .l15_rtrn_ready_o (l15_rtrn_ready_o),
    .l15_rtrn_pid_i   (l15_rtrn_pid_i),
    .l15_rtrn_cmd_i   (l15_rtrn_cmd_i),
    .l15_rtrn_id_i    (l15_rtrn_id_i),
    .l15_rtrn_rdata_i (l15_rtrn_rdata_i),
    .l15_rtrn_error_i (l15_rtrn_error_i),
    .resp_valid_o     (resp_valid_o),
    .resp_ready_i     (resp_ready_i),
    .resp_cmd_o       (resp_cmd_o),
    .resp_id_o        (resp_id_o),
    .resp_rdata_o     (resp_rdata_o),
    .resp_error_o     (resp_error_o)
  );

endmodule

`default_nettype wire

//--- l15_req_arbiter.sv
// L1.5 request arbiter
// Round-robin selection among the request slots. The winner is
// copied into a single output register that drives the L1.5
// request channel, tagged with its port index as the port id.
// A new grant is only given when that register is free or leaves.

`timescale 1ns/1ps
`default_nettype none

module l15_req_arbiter #(
  parameter int  NPORTS = 5,
  parameter int  DATA_W = 64,
  localparam int PID_W  = (NPORTS > 1) ? $clog2(NPORTS) : 1
) (
  input  wire logic                                clk_i,
  input  wire logic                                arst_n_i,
  // Slot side
  input  wire logic                                slot_valid_i     [NPORTS],
  input  l15_adapter_pkg::mem_cmd_e                slot_cmd_i       [NPORTS],
  input  wire logic [l15_adapter_pkg::ADDR_W-1:0]  slot_addr_i      [NPORTS],
  input  wire logic [l15_adapter_pkg::SIZE_W-1:0]  slot_size_i      [NPORTS],
  input  wire logic [l15_adapter_pkg::ID_W-1:0]    slot_id_i        [NPORTS],
  input  wire logic                                slot_cacheable_i [NPORTS],
  input  wire logic [DATA_W-1:0]                   slot_wdata_i     [NPORTS],
  output logic                                     grant_o          [NPORTS],
  // L1.5 request channel
  output logic                                     l15_req_valid_o,
  input  wire logic                                l15_req_ready_i,
  output l15_adapter_pkg::mem_cmd_e                l15_req_cmd_o,
  output logic [l15_adapter_pkg::ADDR_W-1:0]       l15_req_addr_o,
  output logic [l15_adapter_pkg::SIZE_W-1:0]       l15_req_size_o,
  output logic [l15_adapter_pkg::ID_W-1:0]         l15_req_id_o,
  output logic                                     l15_req_cacheable_o,
  output logic [DATA_W-1:0]                        l15_req_wdata_o,
  output logic [PID_W-1:0]                         l15_req_pid_o
);

  l15_adapter_pkg::arb_state_e state_q;

  logic             out_free;
  logic             found;
  logic             take;
  logic [PID_W-1:0] win_idx;
  logic [PID_W-1:0] last_q;
  logic [NPORTS-1:0] grant_vec;

  assign out_free = (state_q == l15_adapter_pkg::ARB_IDLE) || l15_req_ready_i;

  // Search starts one past the last granted port
  always_comb begin
    int idx;
    found   = 1'b0;
    win_idx = '0;
    for (int k = 1; k <= NPORTS; k++) begin
      idx = (int'(last_q) + k) % NPORTS;
      if (!found && slot_valid_i[idx]) begin
        found   = 1'b1;
        win_idx = PID_W'(idx);
      end
    end
  end

  assign take = out_free && found;

  always_comb begin
    for (int p = 0; p < NPORTS; p++) begin
      grant_o[p]   = take && (win_idx == PID_W'(p));
      grant_vec[p] = grant_o[p];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= l15_adapter_pkg::ARB_IDLE;
      last_q  <= PID_W'(NPORTS - 1);
    end else if (out_free) begin
      state_q <= found ? l15_adapter_pkg::ARB_SEND : l15_adapter_pkg::ARB_IDLE;
      if (found) begin
        last_q <= win_idx;
      end
    end
  end

  // Output register, loaded with the winner
  always_ff @(posedge clk_i) begin
    if (take) begin
      l15_req_cmd_o       <= slot_cmd_i[win_idx];
      l15_req_addr_o      <= slot_addr_i[win_idx];
      l15_req_size_o      <= slot_size_i[win_idx];
      l15_req_id_o        <= slot_id_i[win_idx];
      l15_req_cacheable_o <= slot_cacheable_i[win_idx];
      l15_req_wdata_o     <= slot_wdata_i[win_idx];
      l15_req_pid_o       <= win_idx;
    end
  end

  assign l15_req_valid_o = (state_q == l15_adapter_pkg::ARB_SEND);

  a_one_grant : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grant_vec)
  ) else $error("l15_req_arbiter: more than one grant");

  // A stalled request keeps every field until the L1.5 takes it
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    l15_req_valid_o && !l15_req_ready_i |=>
      l15_req_valid_o && $stable(l15_req_cmd_o) && $stable(l15_req_addr_o) &&
      $stable(l15_req_size_o) && $stable(l15_req_id_o) &&
      $stable(l15_req_cacheable_o) && $stable(l15_req_wdata_o) && $stable(l15_req_pid_o)
  ) else $error("l15_req_arbiter: request changed under back-pressure");

endmodule

`default_nettype wire

//--- l15_resp_demux.sv
// L1.5 response demultiplexer
// Registers one L1.5 return and presents it to the requester
// named by its port id. Only that port sees resp_valid_o high.

`timescale 1ns/1ps
`default_nettype none

module l15_resp_demux #(
  parameter int  NPORTS = 5,
  parameter int  DATA_W = 64,
  localparam int PID_W  = (NPORTS > 1) ? $clog2(NPORTS) : 1
) (
  input  wire logic                              clk_i,
  input  wire logic                              arst_n_i,
  // L1.5 return channel
  input  wire logic                              l15_rtrn_valid_i,
  output logic                                   l15_rtrn_ready_o,
  input  wire logic [PID_W-1:0]                  l15_rtrn_pid_i,
  input  l15_adapter_pkg::mem_cmd_e              l15_rtrn_cmd_i,
  input  wire logic [l15_adapter_pkg::ID_W-1:0]  l15_rtrn_id_i,
  input  wire logic [DATA_W-1:0]                 l15_rtrn_rdata_i,
  input  wire logic                              l15_rtrn_error_i,
  // Requester response side
  output logic                                   resp_valid_o [NPORTS],
  input  wire logic                              resp_ready_i [NPORTS],
  output l15_adapter_pkg::mem_cmd_e              resp_cmd_o   [NPORTS],
  output logic [l15_adapter_pkg::ID_W-1:0]       resp_id_o    [NPORTS],
  output logic [DATA_W-1:0]                      resp_rdata_o [NPORTS],
  output logic                                   resp_error_o [NPORTS]
);

  logic                            valid_q;
  logic [PID_W-1:0]                pid_q;
  l15_adapter_pkg::mem_cmd_e       cmd_q;
  logic [l15_adapter_pkg::ID_W-1:0] id_q;
  logic [DATA_W-1:0]               rdata_q;
  logic                            error_q;
  logic                            rtrn_fire;

  // Entry empty, or its port takes it this cycle
  assign l15_rtrn_ready_o = !valid_q || resp_ready_i[pid_q];
  assign rtrn_fire        = l15_rtrn_valid_i && l15_rtrn_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      pid_q   <= '0;
    end else if (rtrn_fire) begin
      valid_q <= 1'b1;
      pid_q   <= l15_rtrn_pid_i;
    end else if (resp_ready_i[pid_q]) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rtrn_fire) begin
      cmd_q   <= l15_rtrn_cmd_i;
      id_q    <= l15_rtrn_id_i;
      rdata_q <= l15_rtrn_rdata_i;
      error_q <= l15_rtrn_error_i;
    end
  end

  // Shared fields, per-port valid
  always_comb begin
    for (int p = 0; p < NPORTS; p++) begin
      resp_valid_o[p] = valid_q && (pid_q == PID_W'(p));
      resp_cmd_o[p]   = cmd_q;
      resp_id_o[p]    = id_q;
      resp_rdata_o[p] = rdata_q;
      resp_error_o[p] = error_q;
    end
  end

  // Port id echoed by the L1.5 must name an existing requester
  a_pid_range : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    rtrn_fire |-> (int'(l15_rtrn_pid_i) < NPORTS)
  ) else $error("l15_resp_demux: return port id out of range");

endmodule

`default_nettype wire

//--- req_slot.sv
// Request slot
// One-entry register buffer between a requester port and the
// request arbiter. A write is only taken together with its data,
// so req_ready_o serves as the ready of both.

`timescale 1ns/1ps
`default_nettype none

module req_slot #(
  parameter int DATA_W = 64
) (
  input  wire logic                                clk_i,
  input  wire logic                                arst_n_i,
  // Requester side
  input  wire logic                                req_valid_i,
  input  l15_adapter_pkg::mem_cmd_e                req_cmd_i,
  input  wire logic [l15_adapter_pkg::ADDR_W-1:0]  req_addr_i,
  input  wire logic [l15_adapter_pkg::SIZE_W-1:0]  req_size_i,
  input  wire logic [l15_adapter_pkg::ID_W-1:0]    req_id_i,
  input  wire logic                                req_cacheable_i,
  input  wire logic                                req_wdata_valid_i,
  input  wire logic [DATA_W-1:0]                   req_wdata_i,
  output logic                                     req_ready_o,
  // Arbiter side
  input  wire logic                                grant_i,
  output logic                                     slot_valid_o,
  output l15_adapter_pkg::mem_cmd_e                slot_cmd_o,
  output logic [l15_adapter_pkg::ADDR_W-1:0]       slot_addr_o,
  output logic [l15_adapter_pkg::SIZE_W-1:0]       slot_size_o,
  output logic [l15_adapter_pkg::ID_W-1:0]         slot_id_o,
  output logic                                     slot_cacheable_o,
  output logic [DATA_W-1:0]                        slot_wdata_o
);

  logic accept;
  logic data_ok;

  // Reads carry no data, writes wait for theirs
  assign data_ok = (req_cmd_i != l15_adapter_pkg::MEM_WRITE) || req_wdata_valid_i;

  // Free, or being drained by the arbiter this cycle
  assign req_ready_o = !slot_valid_o || grant_i;
  assign accept      = req_valid_i && req_ready_o && data_ok;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_valid_o <= 1'b0;
    end else if (accept) begin
      slot_valid_o <= 1'b1;
    end else if (grant_i) begin
      slot_valid_o <= 1'b0;
    end
  end

  // Held request fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_cmd_o       <= req_cmd_i;
      slot_addr_o      <= req_addr_i;
      slot_size_o      <= req_size_i;
      slot_id_o        <= req_id_i;
      slot_cacheable_o <= req_cacheable_i;
      slot_wdata_o     <= req_wdata_i;
    end
  end

  // The arbiter only grants a slot that holds a request
  a_grant_needs_valid : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    grant_i |-> slot_valid_o
  ) else $error("req_slot: grant on empty slot");

endmodule

`default_nettype wire

//--- src.f
l15_adapter_pkg.sv
req_slot.sv
l15_req_arbiter.sv
l15_resp_demux.sv
l15_adapter_top.sv
tb_l15_model.sv
tb_l15_adapter.sv

//--- tb_l15_adapter.sv
// L1.5 adapter testbench
// Runs a table of writes and reads through the requester ports
// against the L1.5 model, then contention, held write data and
// response back-pressure, and reports the error count.

`timescale 1ns/1ps
`default_nettype none

module tb_l15_adapter;

  localparam int NP     = 5;
  localparam int DATA_W = 64;
  localparam int PID_W  = 3;
  localparam int ID_W   = l15_adapter_pkg::ID_W;
  localparam int ADDR_W = l15_adapter_pkg::ADDR_W;

  typedef struct {
    int                        port;
    l15_adapter_pkg::mem_cmd_e cmd;
    logic [ADDR_W-1:0]         addr;
    logic [ID_W-1:0]           id;
    logic [DATA_W-1:0]         wdata;
    logic [DATA_W-1:0]         exp_data;
    logic                      exp_err;
  } entry_t;

  logic clk;
  logic arst_n;
  logic                      req_valid [NP];
  logic                      req_ready [NP];
  l15_adapter_pkg::mem_cmd_e req_cmd [NP];
  logic [ADDR_W-1:0]         req_addr [NP];
  logic [2:0]                req_size [NP];
  logic [ID_W-1:0]           req_id [NP];
  logic                      req_cacheable [NP];
  logic                      req_wdv [NP];
  logic [DATA_W-1:0]         req_wdata [NP];
  logic                      resp_valid [NP];
  logic                      resp_ready [NP];
  l15_adapter_pkg::mem_cmd_e resp_cmd [NP];
  logic [ID_W-1:0]           resp_id [NP];
  logic [DATA_W-1:0]         resp_rdata [NP];
  logic                      resp_error [NP];
  logic                      l15_req_valid, l15_req_ready, l15_req_cacheable;
  l15_adapter_pkg::mem_cmd_e l15_req_cmd;
  logic [ADDR_W-1:0]         l15_req_addr;
  logic [2:0]                l15_req_size;
  logic [ID_W-1:0]           l15_req_id;
  logic [DATA_W-1:0]         l15_req_wdata;
  logic [PID_W-1:0]          l15_req_pid;
  logic                      rtrn_valid, rtrn_ready, rtrn_error;
  logic [PID_W-1:0]          rtrn_pid;
  l15_adapter_pkg::mem_cmd_e rtrn_cmd;
  logic [ID_W-1:0]           rtrn_id;
  logic [DATA_W-1:0]         rtrn_rdata;

  entry_t tbl [$];
  bit     hold_ready [NP];
  int     err_count;
  int     check_count;

  l15_adapter_top #(.NPORTS(NP), .DATA_W(DATA_W)) dut (
    .clk_i(clk), .arst_n_i(arst_n),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_cmd_i(req_cmd),
    .req_addr_i(req_addr), .req_size_i(req_size), .req_id_i(req_id),
    .req_cacheable_i(req_cacheable), .req_wdata_valid_i(req_wdv), .req_wdata_i(req_wdata),
    .resp_valid_o(resp_valid), .resp_ready_i(resp_ready), .resp_cmd_o(resp_cmd),
    .resp_id_o(resp_id), .resp_rdata_o(resp_rdata), .resp_error_o(resp_error),
    .l15_req_valid_o(l15_req_valid), .l15_req_ready_i(l15_req_ready),
    .l15_req_cmd_o(l15_req_cmd), .l15_req_addr_o(l15_req_addr),
    .l15_req_size_o(l15_req_size), .l15_req_id_o(l15_req_id),
    .l15_req_cacheable_o(l15_req_cacheable), .l15_req_wdata_o(l15_req_wdata),
    .l15_req_pid_o(l15_req_pid),
    .l15_rtrn_valid_i(rtrn_valid), .l15_rtrn_ready_o(rtrn_ready), .l15_rtrn_pid_i(rtrn_pid),
    .l15_rtrn_cmd_i(rtrn_cmd), .l15_rtrn_id_i(rtrn_id), .l15_rtrn_rdata_i(rtrn_rdata),
    .l15_rtrn_error_i(rtrn_error)
  );

  tb_l15_model #(.DATA_W(DATA_W), .PID_W(PID_W)) u_model (
    .clk_i(clk), .arst_n_i(arst_n),
    .req_valid_i(l15_req_valid), .req_ready_o(l15_req_ready), .req_cmd_i(l15_req_cmd),
    .req_addr_i(l15_req_addr), .req_id_i(l15_req_id), .req_wdata_i(l15_req_wdata),
    .req_pid_i(l15_req_pid),
    .rtrn_valid_o(rtrn_valid), .rtrn_ready_i(rtrn_ready), .rtrn_pid_o(rtrn_pid),
    .rtrn_cmd_o(rtrn_cmd), .rtrn_id_o(rtrn_id), .rtrn_rdata_o(rtrn_rdata),
    .rtrn_error_o(rtrn_error)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_value(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic check_read_resp(input string tag, input logic [DATA_W-1:0] got_data,
                                 input logic [DATA_W-1:0] exp_data, input logic [ID_W-1:0] got_id,
                                 input logic [ID_W-1:0] exp_id, input logic got_err,
                                 input logic exp_err);
    check_count++;
    if (got_data !== exp_data || got_id !== exp_id || got_err !== exp_err) begin
      fail_value($sformatf("%s read data %h id %0d err %b, expected %h id %0d err %b",
                           tag, got_data, got_id, got_err, exp_data, exp_id, exp_err));
    end
  endtask

  task automatic check_write_resp(input string tag, input l15_adapter_pkg::mem_cmd_e got_cmd,
                                  input logic [ID_W-1:0] got_id, input logic [ID_W-1:0] exp_id,
                                  input logic got_err);
    check_count++;
    if (got_cmd !== l15_adapter_pkg::MEM_WRITE || got_id !== exp_id || got_err !== 1'b0) begin
      fail_value($sformatf("%s write cmd %s id %0d err %b, expected id %0d",
                           tag, got_cmd.name(), got_id, got_err, exp_id));
    end
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_req(input int p, input l15_adapter_pkg::mem_cmd_e cmd,
                          input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                          input logic [DATA_W-1:0] wdata, input logic wdv);
    bit done;
    done = 0;
    req_cmd[p]   = cmd;
    req_addr[p]  = addr;
    req_id[p]    = id;
    req_wdata[p] = wdata;
    req_wdv[p]   = wdv;
    req_valid[p] = 1'b1;
    for (int t = 0; t < 200 && !done; t++) begin
      #1;
      done = req_ready[p] && (cmd == l15_adapter_pkg::MEM_READ || wdv);
      @(negedge clk);
    end
    req_valid[p] = 1'b0;
    if (!done) begin
      $display("Timeout: port %0d request was never accepted", p);
      err_count++;
    end
  endtask

  task automatic get_resp(input int p, input bit solo, output l15_adapter_pkg::mem_cmd_e cmd,
                          output logic [ID_W-1:0] id, output logic [DATA_W-1:0] data,
                          output logic err);
    bit done;
    done = 0;
    for (int t = 0; t < 500 && !done; t++) begin
      resp_ready[p] = hold_ready[p] ? 1'b0 : (($urandom % 4) != 0);
      #1;
      for (int q = 0; q < NP; q++) begin
        if (solo && q != p && resp_valid[q]) begin
          fail_value($sformatf("response on port %0d, expected on port %0d", q, p));
        end
      end
      if (resp_valid[p] && resp_ready[p]) begin
        cmd  = resp_cmd[p];
        id   = resp_id[p];
        data = resp_rdata[p];
        err  = resp_error[p];
        done = 1;
      end
      @(negedge clk);
    end
    resp_ready[p] = 1'b1;
    if (!done) begin
      $display("Timeout: no response arrived on port %0d", p);
      err_count++;
    end
  endtask

  task automatic run_entry(input entry_t e);
    l15_adapter_pkg::mem_cmd_e cmd;
    logic [ID_W-1:0]           id;
    logic [DATA_W-1:0]         data;
    logic                      err;
    send_req(e.port, e.cmd, e.addr, e.id, e.wdata, 1'b1);
    get_resp(e.port, 1, cmd, id, data, err);
    if (e.cmd == l15_adapter_pkg::MEM_WRITE) begin
      check_write_resp($sformatf("port %0d", e.port), cmd, id, e.id, err);
    end else begin
      check_read_resp($sformatf("port %0d", e.port), data, e.exp_data, id, e.id, err, e.exp_err);
    end
  endtask

  function automatic entry_t mk(input int p, input l15_adapter_pkg::mem_cmd_e cmd,
                                input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                                input logic [DATA_W-1:0] d, input logic exp_err);
    entry_t e;
    e.port     = p;
    e.cmd      = cmd;
    e.addr     = addr;
    e.id       = id;
    e.wdata    = d;
    e.exp_data = d;
    e.exp_err  = exp_err;
    return e;
  endfunction

  // Access size that each requester port drives
  function automatic logic [2:0] port_size(input int p);
    return 3'(p % 4);
  endfunction

  // Ports 3 and 4 are the uncached requesters
  function automatic logic port_cacheable(input int p);
    return (p < 3);
  endfunction

  // Stalled L1.5 request must hold every field
  always @(negedge clk) begin
    logic                      pv, pr;
    logic [ADDR_W+DATA_W+ID_W+PID_W+5-1:0] pf;
    #2;
    if (arst_n && pv && !pr && (!l15_req_valid || pf !== {l15_req_cmd, l15_req_addr,
        l15_req_size, l15_req_id, l15_req_cacheable, l15_req_wdata, l15_req_pid})) begin
      fail_value("L1.5 request changed while ready was low");
    end
    // Size and cacheable bit follow the issuing port
    if (arst_n && l15_req_valid && (l15_req_size !== port_size(int'(l15_req_pid)) ||
        l15_req_cacheable !== port_cacheable(int'(l15_req_pid)))) begin
      fail_value($sformatf("L1.5 request of port %0d has size %0d cacheable %b",
                           l15_req_pid, l15_req_size, l15_req_cacheable));
    end
    pv = l15_req_valid;
    pr = l15_req_ready;
    pf = {l15_req_cmd, l15_req_addr, l15_req_size, l15_req_id, l15_req_cacheable,
          l15_req_wdata, l15_req_pid};
  end

  initial begin
    #2_000_000;
    $display("Simulation did not finish within the time limit");
    $display("Verification failed");
    $finish;
  end

  initial begin
    l15_adapter_pkg::mem_cmd_e cmd;
    logic [ID_W-1:0]           id;
    logic [DATA_W-1:0]         data, held_data;
    logic                      err;
    bit                        held_bad;
    void'($urandom(85));
    err_count   = 0;
    check_count = 0;
    arst_n      = 1'b0;
    for (int p = 0; p < NP; p++) begin
      req_valid[p]     = 0;
      req_cmd[p]       = l15_adapter_pkg::MEM_READ;
      req_addr[p]      = '0;
      req_size[p]      = port_size(p);
      req_id[p]        = '0;
      req_cacheable[p] = port_cacheable(p);
      req_wdv[p]       = 1'b0;
      req_wdata[p]     = '0;
      resp_ready[p]    = 1'b1;
      hold_ready[p]    = 0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    #1;
    check_count++;
    for (int p = 0; p < NP; p++) begin
      if (resp_valid[p] || !req_ready[p] || l15_req_valid || !rtrn_ready) begin
        fail_value($sformatf("port %0d wrong idle state after reset", p));
      end
    end
    @(negedge clk);

    // Write on each port, read back from the next port, then out of range
    for (int p = 0; p < NP; p++) begin
      tbl.push_back(mk(p, l15_adapter_pkg::MEM_WRITE, 40'(8 * p), 4'(2 * p + 1),
                       64'h1111_0000_0000_0000 * 64'(p + 1) + 64'(p), 0));
      tbl.push_back(mk((p + 1) % NP, l15_adapter_pkg::MEM_READ, 40'(8 * p), 4'(2 * p + 2),
                       64'h1111_0000_0000_0000 * 64'(p + 1) + 64'(p), 0));
    end
    tbl.push_back(mk(3, l15_adapter_pkg::MEM_READ, 40'h400, 4'd9, '0, 1));
    foreach (tbl[i]) begin
      run_entry(tbl[i]);
    end

    // All ports in the same cycle
    for (int p = 0; p < NP; p++) begin
      fork
        automatic int q = p;
        begin
          l15_adapter_pkg::mem_cmd_e c;
          logic [ID_W-1:0]           i;
          logic [DATA_W-1:0]         d;
          logic                      e;
          send_req(q, l15_adapter_pkg::MEM_READ, 40'(8 * q), 4'(10 + q), '0, 1'b1);
          get_resp(q, 0, c, i, d, e);
          check_read_resp($sformatf("contention port %0d", q), d, tbl[2 * q].wdata,
                          i, 4'(10 + q), e, 1'b0);
        end
      join_none
    end
    wait fork;

    // Write held back by missing data
    req_cmd[2]   = l15_adapter_pkg::MEM_WRITE;
    req_addr[2]  = 40'h0F8;
    req_id[2]    = 4'd5;
    req_wdata[2] = 64'h0BAD_CAFE_1234_5678;
    req_wdv[2]   = 1'b0;
    req_valid[2] = 1'b1;
    repeat (6) begin
      @(negedge clk);
      #1;
      if (l15_req_valid) begin
        fail_value("write was issued without its data");
      end
    end
    @(negedge clk);
    send_req(0, l15_adapter_pkg::MEM_READ, 40'h0F8, 4'd6, '0, 1'b1);
    get_resp(0, 1, cmd, id, data, err);
    check_read_resp("held write old data", data, 64'hDEAD_0000_0000_001F, id, 4'd6, err, 1'b0);
    run_entry(mk(2, l15_adapter_pkg::MEM_WRITE, 40'h0F8, 4'd5, 64'h0BAD_CAFE_1234_5678, 0));
    run_entry(mk(1, l15_adapter_pkg::MEM_READ, 40'h0F8, 4'd7, 64'h0BAD_CAFE_1234_5678, 0));

    // Response back-pressure on port 3
    hold_ready[3] = 1;
    resp_ready[3] = 1'b0;
    send_req(3, l15_adapter_pkg::MEM_READ, 40'h008, 4'd12, '0, 1'b1);
    for (int t = 0; t < 200 && !resp_valid[3]; t++) begin
      @(negedge clk);
      #1;
    end
    if (!resp_valid[3]) begin
      $display("Timeout: held response never appeared on port 3");
      err_count++;
    end
    held_data = resp_rdata[3];
    held_bad  = 0;
    repeat (5) begin
      @(negedge clk);
      #1;
      held_bad |= !resp_valid[3] || resp_rdata[3] !== held_data || resp_id[3] !== 4'd12 ||
                  rtrn_ready !== 1'b0;
    end
    check_count++;
    if (held_bad) begin
      fail_value("held response on port 3 changed under back-pressure");
    end
    @(negedge clk);
    hold_ready[3] = 0;
    get_resp(3, 1, cmd, id, data, err);
    check_read_resp("back-pressure", data, tbl[2].wdata, id, 4'd12, err, 1'b0);

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_l15_model.sv
// L1.5 responder model
// Takes requests with random stalls, keeps a small word memory and
// answers every request in order on the return channel, echoing its
// port id and transaction id. Addresses at or above the limit fail.

`timescale 1ns/1ps
`default_nettype none

module tb_l15_model #(
  parameter int DATA_W = 64,
  parameter int PID_W  = 3
) (
  input  wire logic                                clk_i,
  input  wire logic                                arst_n_i,
  input  wire logic                                req_valid_i,
  output logic                                     req_ready_o,
  input  l15_adapter_pkg::mem_cmd_e                req_cmd_i,
  input  wire logic [l15_adapter_pkg::ADDR_W-1:0]  req_addr_i,
  input  wire logic [l15_adapter_pkg::ID_W-1:0]    req_id_i,
  input  wire logic [DATA_W-1:0]                   req_wdata_i,
  input  wire logic [PID_W-1:0]                    req_pid_i,
  output logic                                     rtrn_valid_o,
  input  wire logic                                rtrn_ready_i,
  output logic [PID_W-1:0]                         rtrn_pid_o,
  output l15_adapter_pkg::mem_cmd_e                rtrn_cmd_o,
  output logic [l15_adapter_pkg::ID_W-1:0]         rtrn_id_o,
  output logic [DATA_W-1:0]                        rtrn_rdata_o,
  output logic                                     rtrn_error_o
);

  localparam int RTRN_W = PID_W + 1 + l15_adapter_pkg::ID_W + DATA_W + 1;
  localparam logic [l15_adapter_pkg::ADDR_W-1:0] ADDR_LIMIT = 'h200;

  logic [DATA_W-1:0] mem [64];
  logic [RTRN_W-1:0] rtrn_q [$];

  // Fill word carries its own index
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 64'hDEAD_0000_0000_0000 | 64'(i);
    end
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    logic              err;
    logic [DATA_W-1:0] rdata;
    if (!arst_n_i) begin
      rtrn_q.delete();
    end else begin
      if (rtrn_valid_o && rtrn_ready_i) begin
        void'(rtrn_q.pop_front());
      end
      if (req_valid_i && req_ready_o) begin
        err   = (req_addr_i >= ADDR_LIMIT);
        rdata = '0;
        if (!err && req_cmd_i == l15_adapter_pkg::MEM_WRITE) begin
          mem[req_addr_i[8:3]] = req_wdata_i;
        end else if (!err) begin
          rdata = mem[req_addr_i[8:3]];
        end
        rtrn_q.push_back({req_pid_i, req_cmd_i, req_id_i, rdata, err});
      end
    end
  end

  // Outputs change on the falling edge only
  always @(negedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_ready_o  <= 1'b0;
      rtrn_valid_o <= 1'b0;
      {rtrn_pid_o, rtrn_cmd_o, rtrn_id_o, rtrn_rdata_o, rtrn_error_o} <= '0;
    end else begin
      req_ready_o  <= ($urandom % 4) != 0;
      rtrn_valid_o <= rtrn_q.size() > 0;
      if (rtrn_q.size() > 0) begin
        {rtrn_pid_o, rtrn_cmd_o, rtrn_id_o, rtrn_rdata_o, rtrn_error_o} <= rtrn_q[0];
      end
    end
  end

endmodule

`default_nettype wire
